// File: branchResolver.sv
`timescale 1ns/1ns
`default_nettype none

module branchResolver import isaPkg::*; (
    input instrWord instrD,
    input logic [31:0] pcPlus4,
    input logic [31:0] readData1,
    input logic [31:0] readData2,
    input logic [31:0] forwardValue,
    input logic forwardA,
    input logic forwardB,
    input logic branch,
    output logic [31:0] signImm,
    output logic [31:0] pcBranch,
    output logic pcSrc
);

    logic [31:0] operandA;
    logic [31:0] operandB;
    logic operandsEqual;

    // 16-bit immediate widened with its sign bit
    assign signImm = {{(32 - immWidth){instrD.iType.imm[immWidth-1]}}, instrD.iType.imm};

    // word offset relative to the next PC
    assign pcBranch = pcPlus4 + {signImm[29:0], 2'b00};

    // results still in flight come from the hazard unit's forward path
    assign operandA = forwardA ? forwardValue : readData1;
    assign operandB = forwardB ? forwardValue : readData2;

    assign operandsEqual = (operandA == operandB);

    // beq taken in decode, no penalty beyond the fetched slot
    assign pcSrc = branch && operandsEqual;

endmodule

`default_nettype wire

// File: controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit import isaPkg::*, pipePkg::*; (
    input instrWord instrD,
    ctrlBus.decoder ctrl
);

    logic opKnown;
    logic functKnown;
    logic regWriteM;
    logic memtoRegM;
    logic memWriteM;
    logic memReadM;
    logic aluSrcM;
    logic regDstM;
    logic branchM;
    logic [aluOpWidth-1:0] aluOp;
    logic [aluCtrlWidth-1:0] aluCtrlRaw;
    logic valid;

    // main decoder on the opcode
    always_comb begin
        opKnown = 1'b1;
        regWriteM = 1'b0;
        memtoRegM = 1'b0;
        memWriteM = 1'b0;
        memReadM = 1'b0;
        aluSrcM = 1'b0;
        regDstM = 1'b0;
        branchM = 1'b0;
        aluOp = aluOpAdd;
        case (instrD.rType.op)
            opRtype: begin
                regWriteM = 1'b1;
                regDstM = 1'b1;
                aluOp = aluOpFunct;
            end
            opLw: begin
                regWriteM = 1'b1;
                aluSrcM = 1'b1;
                memtoRegM = 1'b1;
                memReadM = 1'b1;
            end
            opSw: begin
                aluSrcM = 1'b1;
                memWriteM = 1'b1;
            end
            opBeq: begin
                branchM = 1'b1;
                aluOp = aluOpSub;
            end
            opAddi: begin
                regWriteM = 1'b1;
                aluSrcM = 1'b1;
            end
            default: opKnown = 1'b0;
        endcase
    end

    // ALU decoder, funct only matters for the R-type group
    always_comb begin
        functKnown = 1'b1;
        case (aluOp)
            aluOpAdd: aluCtrlRaw = aluAdd;
            aluOpSub: aluCtrlRaw = aluSub;
            aluOpFunct: begin
                case (instrD.rType.funct)
                    fnAdd: aluCtrlRaw = aluAdd;
                    fnSub: aluCtrlRaw = aluSub;
                    fnAnd: aluCtrlRaw = aluAnd;
                    fnOr: aluCtrlRaw = aluOr;
                    fnSlt: aluCtrlRaw = aluSlt;
                    default: begin
                        aluCtrlRaw = aluAnd;
                        functKnown = 1'b0;
                    end
                endcase
            end
            default: aluCtrlRaw = aluAnd;
        endcase
    end

    // anything unsupported comes out as a bubble
    assign valid = opKnown && functKnown;

    assign ctrl.regWrite = valid && regWriteM;
    assign ctrl.memtoReg = valid && memtoRegM;
    assign ctrl.memWrite = valid && memWriteM;
    assign ctrl.memRead = valid && memReadM;
    assign ctrl.aluSrc = valid && aluSrcM;
    assign ctrl.regDst = valid && regDstM;
    assign ctrl.branch = valid && branchM;
    assign ctrl.aluControl = valid ? aluCtrlRaw : aluAnd;

endmodule

`default_nettype wire

// File: ctrlBus.sv
`timescale 1ns/1ns
`default_nettype none

// decoded controls of the instruction in decode, valid in the same cycle
interface ctrlBus import pipePkg::*; ();

    logic regWrite;
    logic memtoReg;
    logic memWrite;
    logic memRead;
    logic aluSrc;
    logic regDst;
    logic branch;
    logic [aluCtrlWidth-1:0] aluControl;

    modport decoder (
        output regWrite, memtoReg, memWrite, memRead,
        output aluSrc, regDst, branch, aluControl
    );

    modport stage (
        input regWrite, memtoReg, memWrite, memRead,
        input aluSrc, regDst, branch, aluControl
    );

endinterface

`default_nettype wire

// File: decodeCases.txt
// tag instrD pcPlus4D inFlags(regWriteW fwdA fwdB flushE) writeAddrW writeDataW forwardValueD
// pcSrcD pcBranchD ctrlE(regWr memtoReg memWr memRd aluSrc regDst branch) aluE rd1E rd2E immE rs rt rd
// tag c0..c3 is a case: bit0 random PC and no target check, bit1 random forward value; e0 ends
// reset state, then writes with bypass and a write to register 0
c3 00221820 0 0000 00 0 0 0 0 1000010 2 0 0 00001820 01 02 03
c3 00222024 0 1000 01 11111111 0 0 0 1000010 0 11111111 0 00002024 01 02 04
c3 00222825 0 1000 02 22222222 0 0 0 1000010 1 11111111 22222222 00002825 01 02 05
c3 00023022 0 1000 00 deadbeef 0 0 0 1000010 6 0 22222222 00003022 00 02 06
c3 0041382a 0 0000 00 0 0 0 0 1000010 7 22222222 11111111 0000382a 02 01 07
// lw, sw, addi, unknown opcode, unknown funct
c3 8c08fffc 0 0000 00 0 0 0 0 1101100 2 0 0 fffffffc 00 08 1f
c3 ac220008 0 0000 00 0 0 0 0 0010100 2 11111111 22222222 00000008 01 02 00
c3 20297fff 0 1000 09 99 0 0 0 1000100 2 11111111 99 00007fff 01 09 0f
c3 fc221234 0 0000 00 0 0 0 0 0000000 0 11111111 22222222 00001234 01 02 02
c3 00221800 0 0000 00 0 0 0 0 0000000 0 11111111 22222222 00001800 01 02 03
// beq taken and not taken, then with forwarding
c2 1021fffc 00001000 0000 00 0 0 1 00000ff0 0000001 6 11111111 11111111 fffffffc 01 01 1f
c2 10220010 00002000 0000 00 0 0 0 00002040 0000001 6 11111111 22222222 00000010 01 02 00
c0 10220010 00003000 0100 00 0 22222222 1 00003040 0000001 6 11111111 22222222 00000010 01 02 00
c0 1022fffc 00004000 0010 00 0 11111111 1 00003ff0 0000001 6 11111111 22222222 fffffffc 01 02 1f
c0 1021fffc 00005000 0100 00 0 12345678 0 00004ff0 0000001 6 11111111 11111111 fffffffc 01 01 1f
c0 10220010 00006000 0110 00 0 abcdef01 1 00006040 0000001 6 11111111 22222222 00000010 01 02 00
c3 00211820 0 0000 00 0 0 0 0 1000010 2 11111111 11111111 00001820 01 01 03
// flush, with a write that must still land
c2 1021fffc 00007000 0001 00 0 0 1 00006ff0 0000000 0 0 0 0 0 0 0
c3 01425820 0 1001 0a a0a0a0a0 0 0 0 0000000 0 0 0 0 0 0 0
// back to back through the pipeline register
c3 01425820 0 1000 0b 0000000b 0 0 0 1000010 2 a0a0a0a0 22222222 00005820 0a 02 0b
c3 ad6c0020 0 1000 0c cccccccc 0 0 0 0010100 2 0000000b cccccccc 00000020 0b 0c 00
c3 00216824 0 1000 01 0badf00d 0 0 0 1000010 0 0badf00d 0badf00d 00006824 01 01 0d
c0 102c0003 00008000 0010 00 0 0badf00d 1 0000800c 0000001 6 0badf00d cccccccc 00000003 01 0c 00
c3 0181702a 0 0000 00 0 0 0 0 1000010 7 cccccccc 0badf00d 0000702a 0c 01 0e
c3 23ffffff 0 1000 1f ffffffff 0 0 0 1000100 2 ffffffff ffffffff ffffffff 1f 1f 1f
c3 08000010 0 0000 00 0 0 0 0 0000000 0 0 0 00000010 00 00 00
e0

// File: decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage import isaPkg::*, pipePkg::*; (
    input logic clk,
    input logic reset,
    input logic flushE,
    input logic regWriteW,
    input logic forwardAD,
    input logic forwardBD,
    input logic [31:0] instrD,
    input logic [31:0] pcPlus4D,
    input logic [31:0] writeDataW,
    input logic [31:0] forwardValueD,
    input logic [regAddrWidth-1:0] writeAddrW,
    output logic [31:0] pcBranchD,
    output logic pcSrcD,
    output logic [regAddrWidth-1:0] rsD,
    output logic [regAddrWidth-1:0] rtD,
    output logic regWriteE,
    output logic memtoRegE,
    output logic memWriteE,
    output logic memReadE,
    output logic aluSrcE,
    output logic regDstE,
    output logic branchE,
    output logic [aluCtrlWidth-1:0] aluControlE,
    output logic [31:0] readData1E,
    output logic [31:0] readData2E,
    output logic [31:0] signImmE,
    output logic [regAddrWidth-1:0] rsE,
    output logic [regAddrWidth-1:0] rtE,
    output logic [regAddrWidth-1:0] rdE
);

    instrWord instr;
    logic [31:0] readData1;
    logic [31:0] readData2;
    logic [31:0] signImm;

    ctrlBus ctrlIf ();

    assign instr = instrD;

    // source registers go out to the hazard unit
    assign rsD = instr.rType.rs;
    assign rtD = instr.rType.rt;

    controlUnit controlUnit_i (
        .instrD (instr),
        .ctrl   (ctrlIf)
    );

    registerFile registerFile_i (
        .clk         (clk),
        .reset       (reset),
        .readAddr1   (instr.rType.rs),
        .readAddr2   (instr.rType.rt),
        .writeAddr   (writeAddrW),
        .writeEnable (regWriteW),
        .writeData   (writeDataW),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    branchResolver branchResolver_i (
        .instrD       (instr),
        .pcPlus4      (pcPlus4D),
        .readData1    (readData1),
        .readData2    (readData2),
        .forwardValue (forwardValueD),
        .forwardA     (forwardAD),
        .forwardB     (forwardBD),
        .branch       (ctrlIf.branch),
        .signImm      (signImm),
        .pcBranch     (pcBranchD),
        .pcSrc        (pcSrcD)
    );

    idExRegister idExRegister_i (
        .clk         (clk),
        .reset       (reset),
        .flush       (flushE),
        .ctrl        (ctrlIf),
        .readData1   (readData1),
        .readData2   (readData2),
        .signImm     (signImm),
        .instrD      (instr),
        .regWriteE   (regWriteE),
        .memtoRegE   (memtoRegE),
        .memWriteE   (memWriteE),
        .memReadE    (memReadE),
        .aluSrcE     (aluSrcE),
        .regDstE     (regDstE),
        .branchE     (branchE),
        .aluControlE (aluControlE),
        .readData1E  (readData1E),
        .readData2E  (readData2E),
        .signImmE    (signImmE),
        .rsE         (rsE),
        .rtE         (rtE),
        .rdE         (rdE)
    );

endmodule

`default_nettype wire

// File: idExRegister.sv
`timescale 1ns/1ns
`default_nettype none

module idExRegister import isaPkg::*, pipePkg::*; (
    input logic clk,
    input logic reset,
    input logic flush,
    ctrlBus.stage ctrl,
    input logic [31:0] readData1,
    input logic [31:0] readData2,
    input logic [31:0] signImm,
    input instrWord instrD,
    output logic regWriteE,
    output logic memtoRegE,
    output logic memWriteE,
    output logic memReadE,
    output logic aluSrcE,
    output logic regDstE,
    output logic branchE,
    output logic [aluCtrlWidth-1:0] aluControlE,
    output logic [31:0] readData1E,
    output logic [31:0] readData2E,
    output logic [31:0] signImmE,
    output logic [regAddrWidth-1:0] rsE,
    output logic [regAddrWidth-1:0] rtE,
    output logic [regAddrWidth-1:0] rdE
);

    // flush turns the slot into a bubble, reset does the same at any time
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regWriteE <= 1'b0;
            memtoRegE <= 1'b0;
            memWriteE <= 1'b0;
            memReadE <= 1'b0;
            aluSrcE <= 1'b0;
            regDstE <= 1'b0;
            branchE <= 1'b0;
            aluControlE <= '0;
            readData1E <= '0;
            readData2E <= '0;
            signImmE <= '0;
            rsE <= '0;
            rtE <= '0;
            rdE <= '0;
        end else if (flush) begin
            regWriteE <= 1'b0;
            memtoRegE <= 1'b0;
            memWriteE <= 1'b0;
            memReadE <= 1'b0;
            aluSrcE <= 1'b0;
            regDstE <= 1'b0;
            branchE <= 1'b0;
            aluControlE <= '0;
            readData1E <= '0;
            readData2E <= '0;
            signImmE <= '0;
            rsE <= '0;
            rtE <= '0;
            rdE <= '0;
        end else begin
            regWriteE <= ctrl.regWrite;
            memtoRegE <= ctrl.memtoReg;
            memWriteE <= ctrl.memWrite;
            memReadE <= ctrl.memRead;
            aluSrcE <= ctrl.aluSrc;
            regDstE <= ctrl.regDst;
            branchE <= ctrl.branch;
            aluControlE <= ctrl.aluControl;
            readData1E <= readData1;
            readData2E <= readData2;
            signImmE <= signImm;
            // rs and rt for forwarding in execute, rd for the write target mux
            rsE <= instrD.rType.rs;
            rtE <= instrD.rType.rt;
            rdE <= instrD.rType.rd;
        end
    end

endmodule

`default_nettype wire

// File: isaPkg.sv
`default_nettype none

package isaPkg;

    // field widths of a MIPS instruction word
    localparam int opWidth = 6;
    localparam int functWidth = 6;
    localparam int shamtWidth = 5;
    localparam int immWidth = 16;
    localparam int regAddrWidth = 5;

    // major opcodes, instr[31:26]
    localparam logic [opWidth-1:0] opRtype = 6'b000000;
    localparam logic [opWidth-1:0] opLw = 6'b100011;
    localparam logic [opWidth-1:0] opSw = 6'b101011;
    localparam logic [opWidth-1:0] opBeq = 6'b000100;
    localparam logic [opWidth-1:0] opAddi = 6'b001000;

    // funct codes of the R-type group, instr[5:0]
    localparam logic [functWidth-1:0] fnAdd = 6'b100000;
    localparam logic [functWidth-1:0] fnSub = 6'b100010;
    localparam logic [functWidth-1:0] fnAnd = 6'b100100;
    localparam logic [functWidth-1:0] fnOr = 6'b100101;
    localparam logic [functWidth-1:0] fnSlt = 6'b101010;

    // one fetched word, read either as R-type or as I-type
    // op, rs and rt sit at the same bits in both views
    typedef union packed {
        struct packed {
            logic [opWidth-1:0] op;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [shamtWidth-1:0] shamt;
            logic [functWidth-1:0] funct;
        } rType;
        struct packed {
            logic [opWidth-1:0] op;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [immWidth-1:0] imm;
        } iType;
    } instrWord;

endpackage

`default_nettype wire

// File: pipePkg.sv
`default_nettype none

package pipePkg;

    // ALU control word carried down the pipe to execute
    localparam int aluCtrlWidth = 3;

    localparam logic [aluCtrlWidth-1:0] aluAnd = 3'b000;
    localparam logic [aluCtrlWidth-1:0] aluOr = 3'b001;
    localparam logic [aluCtrlWidth-1:0] aluAdd = 3'b010;
    localparam logic [aluCtrlWidth-1:0] aluSub = 3'b110;
    localparam logic [aluCtrlWidth-1:0] aluSlt = 3'b111;

    // code from the main decoder to the ALU decoder
    localparam int aluOpWidth = 2;

    localparam logic [aluOpWidth-1:0] aluOpAdd = 2'b00;
    localparam logic [aluOpWidth-1:0] aluOpSub = 2'b01;
    // look at funct to pick the operation
    localparam logic [aluOpWidth-1:0] aluOpFunct = 2'b10;

endpackage

`default_nettype wire

// File: registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile import isaPkg::*; (
    input logic clk,
    input logic reset,
    input logic [regAddrWidth-1:0] readAddr1,
    input logic [regAddrWidth-1:0] readAddr2,
    input logic [regAddrWidth-1:0] writeAddr,
    input logic writeEnable,
    input logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    // $zero is not stored, only 1..31 are real registers
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // one read port, with the writeback value bypassed in the write cycle
    function automatic logic [31:0] readPort(input logic [regAddrWidth-1:0] addr);
        logic [31:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (writeEnable && addr == writeAddr) begin
            value = writeData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    assign readData1 = readPort(readAddr1);
    assign readData2 = readPort(readAddr2);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the decode stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tbDecodeStage; then
    echo "build failed"
    exit 1
fi

simOutput=$(./obj_dir/VtbDecodeStage 2>&1)
simStatus=$?
echo "$simOutput"
if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
fi

if echo "$simOutput" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// File: tbDecodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module tbDecodeStage;

    localparam int recWords = 17;
    localparam int maxCases = 64;
    localparam int resetCycles = 16;
    localparam int resetTimeout = 40;

    logic clk;
    logic reset;
    logic flushE;
    logic regWriteW;
    logic forwardAD;
    logic forwardBD;
    logic [31:0] instrD;
    logic [31:0] pcPlus4D;
    logic [31:0] writeDataW;
    logic [31:0] forwardValueD;
    logic [4:0] writeAddrW;
    logic [31:0] pcBranchD;
    logic pcSrcD;
    logic [4:0] rsD;
    logic [4:0] rtD;
    logic regWriteE;
    logic memtoRegE;
    logic memWriteE;
    logic memReadE;
    logic aluSrcE;
    logic regDstE;
    logic branchE;
    logic [2:0] aluControlE;
    logic [31:0] readData1E;
    logic [31:0] readData2E;
    logic [31:0] signImmE;
    logic [4:0] rsE;
    logic [4:0] rtE;
    logic [4:0] rdE;

    // flat image of the case file with recWords words per case
    logic [31:0] caseMem [0:(maxCases + 1) * recWords - 1];
    // E-side values due after the coming edge in the order ctrl alu rd1 rd2 imm rs rt rd
    logic [31:0] expectE [0:7];

    decodeStage decodeStage_i (.*);

    always #2 clk = ~clk;

    initial begin
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;
    end

    task automatic failRun;
        $display("STATUS: FAIL");
        $fatal(1, "decode stage run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h",
                     $time, name, actual, expected);
            failRun();
        end
    endtask

    // control flags sit one per nibble in the first expected word
    task automatic checkStageOutputs;
        checkValue("regWriteE", 32'(regWriteE), 32'(expectE[0][24]));
        checkValue("memtoRegE", 32'(memtoRegE), 32'(expectE[0][20]));
        checkValue("memWriteE", 32'(memWriteE), 32'(expectE[0][16]));
        checkValue("memReadE", 32'(memReadE), 32'(expectE[0][12]));
        checkValue("aluSrcE", 32'(aluSrcE), 32'(expectE[0][8]));
        checkValue("regDstE", 32'(regDstE), 32'(expectE[0][4]));
        checkValue("branchE", 32'(branchE), 32'(expectE[0][0]));
        checkValue("aluControlE", 32'(aluControlE), expectE[1]);
        checkValue("readData1E", readData1E, expectE[2]);
        checkValue("readData2E", readData2E, expectE[3]);
        checkValue("signImmE", signImmE, expectE[4]);
        checkValue("rsE", 32'(rsE), expectE[5]);
        checkValue("rtE", 32'(rtE), expectE[6]);
        checkValue("rdE", 32'(rdE), expectE[7]);
    endtask

    task automatic applyCase(input int base);
        logic [31:0] flags;
        flags = caseMem[base + 3];
        instrD = caseMem[base + 1];
        if (caseMem[base][0]) begin
            pcPlus4D = $urandom();
        end else begin
            pcPlus4D = caseMem[base + 2];
        end
        regWriteW = flags[12];
        forwardAD = flags[8];
        forwardBD = flags[4];
        flushE = flags[0];
        writeAddrW = caseMem[base + 4][4:0];
        writeDataW = caseMem[base + 5];
        if (caseMem[base][1]) begin
            forwardValueD = $urandom();
        end else begin
            forwardValueD = caseMem[base + 6];
        end
    endtask

    task automatic checkDecodeOutputs(input int base);
        checkValue("pcSrcD", 32'(pcSrcD), caseMem[base + 7]);
        // no fixed target to compare with when the PC is random
        if (!caseMem[base][0]) begin
            checkValue("pcBranchD", pcBranchD, caseMem[base + 8]);
        end
        checkValue("rsD", 32'(rsD), 32'(instrD[25:21]));
        checkValue("rtD", 32'(rtD), 32'(instrD[20:16]));
    endtask

    initial begin
        int base;
        int caseCount;
        int waited;
        void'($urandom(32'h3b4c_5bbf));
        clk = 1'b0;
        reset = 1'b1;
        flushE = 1'b0;
        regWriteW = 1'b0;
        forwardAD = 1'b0;
        forwardBD = 1'b0;
        instrD = '0;
        pcPlus4D = '0;
        writeDataW = '0;
        forwardValueD = '0;
        writeAddrW = '0;
        for (int i = 0; i < 8; i++) begin
            expectE[i] = '0;
        end
        $readmemh("decodeCases.txt", caseMem);

        waited = 0;
        while (reset && waited < resetTimeout) begin
            @(posedge clk);
            waited++;
        end
        if (reset) begin
            $display("timed out after %0d cycles waiting for reset release", resetTimeout);
            failRun();
        end

        // first pass checks the all-zero state left by reset
        base = 0;
        caseCount = 0;
        #1;
        while (caseMem[base][7:4] == 4'hc && caseCount < maxCases) begin
            checkStageOutputs();
            applyCase(base);
            #2;
            checkDecodeOutputs(base);
            for (int i = 0; i < 8; i++) begin
                expectE[i] = caseMem[base + 9 + i];
            end
            base += recWords;
            caseCount++;
            @(posedge clk);
            #1;
        end
        if (caseMem[base] !== 32'he0) begin
            $display("case file gave no end record after %0d cases", caseCount);
            failRun();
        end else begin
            checkStageOutputs();
            $display("checked %0d cases", caseCount);
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
isaPkg.sv
pipePkg.sv
ctrlBus.sv
controlUnit.sv
registerFile.sv
branchResolver.sv
idExRegister.sv
decodeStage.sv
tbDecodeStage.sv
